/* rtl/vc_router_pkg.sv */
// constants, direction codes and the flit word shared by every block of the VC router
package vc_router_pkg;

  // ====================
  // sizes
  // ====================

  // five ports in the order N, E, S, W, L
  localparam int NUM_PORTS  = 5;
  localparam int PORT_W     = 3;
  // static VCs, a flit keeps its VC id through the router
  localparam int NUM_VC     = 2;
  localparam int VC_ID_W    = 1;
  // fifo depth per VC, also the credit count after reset
  localparam int VC_DEPTH   = 2;
  localparam int CRED_W     = 2;
  localparam int FIFO_PTR_W = 1;
  localparam int COORD_W    = 2;
  localparam int PAYLOAD_W  = 16;
  localparam int FLIT_W     = 20;
  // padding so that both views fill the same flit word
  localparam int HEAD_PAD_W = FLIT_W - 2 - VC_ID_W - PORT_W - 2 * COORD_W;
  localparam int BODY_PAD_W = FLIT_W - 2 - VC_ID_W - PAYLOAD_W;

  // ====================
  // directions
  // ====================

  // port index and look-ahead code are the same number
  localparam logic [PORT_W-1:0] DIR_N = 3'd0;
  localparam logic [PORT_W-1:0] DIR_E = 3'd1;
  localparam logic [PORT_W-1:0] DIR_S = 3'd2;
  localparam logic [PORT_W-1:0] DIR_W = 3'd3;
  localparam logic [PORT_W-1:0] DIR_L = 3'd4;

  // ====================
  // flit word
  // ====================

  // head and body share the leading flags and the VC id
  typedef union packed {
    struct packed {
      logic                  is_head;
      logic                  is_last;
      logic [VC_ID_W-1:0]    vc_id;
      // output to take at the router that holds the flit
      logic [PORT_W-1:0]     la_dir;
      logic [COORD_W-1:0]    dst_x;
      logic [COORD_W-1:0]    dst_y;
      logic [HEAD_PAD_W-1:0] pad;
    } head;
    struct packed {
      logic                  is_head;
      logic                  is_last;
      logic [VC_ID_W-1:0]    vc_id;
      logic [PAYLOAD_W-1:0]  payload;
      logic [BODY_PAD_W-1:0] pad;
    } body;
  } flit_u;

endpackage

/* rtl/vc_head_if.sv */
// head flits of one input port toward its local switch arbiter, and the pop that removes one
interface vc_head_if;

  // one valid bit and one head flit per VC
  logic [vc_router_pkg::NUM_VC-1:0]                 head_v;
  vc_router_pkg::flit_u [vc_router_pkg::NUM_VC-1:0] head;

  // pop removes the head of pop_vc at the next edge
  logic                                             pop;
  logic [vc_router_pkg::VC_ID_W-1:0]                pop_vc;

  // fifo side
  modport queue (
    output head_v, head,
    input  pop, pop_vc
  );

  // arbiter side
  modport arb (
    input  head_v, head,
    output pop, pop_vc
  );

endinterface

/* rtl/vc_input_port.sv */
// input port of the router: one flit FIFO per VC, heads to the local arbiter, credits upstream
module vc_input_port (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              data_v_i,
  input  vc_router_pkg::flit_u              data_i,
  output logic                              credit_v_o,
  output logic [vc_router_pkg::VC_ID_W-1:0] credit_id_o,
  vc_head_if.queue                          hd
);

  // VC id sits in the same bits for heads and bodies
  logic [vc_router_pkg::VC_ID_W-1:0] wr_vc;

  assign wr_vc = data_i.head.vc_id;

  // ====================
  // fifo per VC
  // ====================

  for (genvar v = 0; v < vc_router_pkg::NUM_VC; v++) begin : gen_vc
    logic                                 push;
    logic                                 pop;
    logic [vc_router_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
    logic [vc_router_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
    logic [vc_router_pkg::CRED_W-1:0]     cnt_q;
    vc_router_pkg::flit_u                 mem_q [vc_router_pkg::VC_DEPTH];

    assign push = data_v_i && (wr_vc == vc_router_pkg::VC_ID_W'(v));
    assign pop  = hd.pop && (hd.pop_vc == vc_router_pkg::VC_ID_W'(v));

    // pointers wrap at the depth, count tracks the fill level
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == vc_router_pkg::FIFO_PTR_W'(vc_router_pkg::VC_DEPTH - 1)) ?
                      '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == vc_router_pkg::FIFO_PTR_W'(vc_router_pkg::VC_DEPTH - 1)) ?
                      '0 : rd_ptr_q + 1'b1;
        end
        cnt_q <= cnt_q + vc_router_pkg::CRED_W'(push) - vc_router_pkg::CRED_W'(pop);
      end
    end

    // flit storage
    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= data_i;
      end
    end

    // head is valid as long as something is stored
    assign hd.head_v[v] = (cnt_q != '0);
    assign hd.head[v]   = mem_q[rd_ptr_q];

    // upstream only sends on a held credit, so a full VC is never written
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      push |-> (cnt_q < vc_router_pkg::CRED_W'(vc_router_pkg::VC_DEPTH)));
  end

  // ====================
  // credit return
  // ====================

  // one pulse per popped flit, in the cycle after the pop
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_v_o <= 1'b0;
    end else begin
      credit_v_o <= hd.pop;
    end
  end

  always_ff @(posedge clk_i) begin
    credit_id_o <= hd.pop_vc;
  end

endmodule

/* rtl/vc_sa_local.sv */
// first switch allocation stage: round-robin over the VCs of one input, requests one output
module vc_sa_local (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  vc_head_if.arb                                 hd,
  // eligibility of each output VC for this input
  input  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::NUM_VC-1:0] vc_ok_i,
  input  logic                                   grant_i,
  output logic [vc_router_pkg::NUM_PORTS-1:0]    req_o,
  output logic [vc_router_pkg::VC_ID_W-1:0]      req_vc_o,
  output vc_router_pkg::flit_u                   req_flit_o
);

  logic [vc_router_pkg::NUM_VC-1:0][vc_router_pkg::PORT_W-1:0] tgt;
  // output held by the packet in flight on each VC
  logic [vc_router_pkg::NUM_VC-1:0][vc_router_pkg::PORT_W-1:0] out_dir_q;
  logic [vc_router_pkg::NUM_VC-1:0]                            cand;
  logic [vc_router_pkg::VC_ID_W-1:0]                           rr_q;
  logic [vc_router_pkg::VC_ID_W-1:0]                           sel;
  logic                                                        sel_v;

  // heads steer by look-ahead, bodies follow their head
  always_comb begin
    for (int v = 0; v < vc_router_pkg::NUM_VC; v++) begin
      tgt[v]  = hd.head[v].head.is_head ? hd.head[v].head.la_dir : out_dir_q[v];
      cand[v] = hd.head_v[v] && vc_ok_i[tgt[v]][v];
    end
  end

  // ====================
  // round robin
  // ====================

  // scan from the highest offset down, so the VC nearest the pointer wins
  always_comb begin
    int idx;
    sel_v = 1'b0;
    sel   = rr_q;
    for (int i = vc_router_pkg::NUM_VC - 1; i >= 0; i--) begin
      idx = (int'(rr_q) + i) % vc_router_pkg::NUM_VC;
      if (cand[idx]) begin
        sel_v = 1'b1;
        sel   = vc_router_pkg::VC_ID_W'(idx);
      end
    end
  end

  assign req_o      = sel_v ? (vc_router_pkg::NUM_PORTS'(1) << tgt[sel]) : '0;
  assign req_vc_o   = sel;
  assign req_flit_o = hd.head[sel];

  // a grant pops the chosen head right away
  assign hd.pop     = grant_i;
  assign hd.pop_vc  = sel;

  // pointer moves past the winner only on a grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q      <= '0;
      out_dir_q <= '0;
    end else if (grant_i) begin
      rr_q <= (sel == vc_router_pkg::VC_ID_W'(vc_router_pkg::NUM_VC - 1)) ? '0 : sel + 1'b1;
      if (req_flit_o.head.is_head) begin
        out_dir_q[sel] <= tgt[sel];
      end
    end
  end

  // at most one output asked for, and the global stage only grants a live request
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(req_o) && (!grant_i || (req_o != '0)));

endmodule

/* rtl/vc_sa_global.sv */
// second switch allocation stage that round-robins over the inputs requesting one output
module vc_sa_global (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // own port's bit is tied low, so only the four other inputs compete
  input  logic [vc_router_pkg::NUM_PORTS-1:0] req_i,
  output logic [vc_router_pkg::NUM_PORTS-1:0] grant_o,
  output logic                                win_o,
  output logic [vc_router_pkg::PORT_W-1:0]    win_in_o
);

  logic [vc_router_pkg::PORT_W-1:0] rr_q;

  // nearest requester at or after the pointer wins
  always_comb begin
    int idx;
    win_o    = 1'b0;
    win_in_o = rr_q;
    for (int i = vc_router_pkg::NUM_PORTS - 1; i >= 0; i--) begin
      idx = (int'(rr_q) + i) % vc_router_pkg::NUM_PORTS;
      if (req_i[idx]) begin
        win_o    = 1'b1;
        win_in_o = vc_router_pkg::PORT_W'(idx);
      end
    end
  end

  assign grant_o = win_o ? (vc_router_pkg::NUM_PORTS'(1) << win_in_o) : '0;

  // pointer steps past each winner
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (win_o) begin
      rr_q <= (win_in_o == vc_router_pkg::PORT_W'(vc_router_pkg::NUM_PORTS - 1)) ?
              '0 : win_in_o + 1'b1;
    end
  end

  // single grant, and the last winner yields to any other input that asks
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant_o) &&
    (!($past(win_o) && ((req_i & ~$past(grant_o)) != '0)) ||
     (grant_o != $past(grant_o))));

endmodule

/* rtl/vc_output_credits.sv */
// downstream credit counters and packet locks of every output VC, with eligibility per input
module vc_output_credits (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [vc_router_pkg::NUM_PORTS-1:0] credit_v_i,
  input  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::VC_ID_W-1:0] credit_id_i,
  input  logic [vc_router_pkg::NUM_PORTS-1:0] win_i,
  input  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::PORT_W-1:0] win_in_i,
  input  vc_router_pkg::flit_u [vc_router_pkg::NUM_PORTS-1:0] win_flit_i,
  // indexed [input][output][vc]
  output logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::NUM_PORTS-1:0]
               [vc_router_pkg::NUM_VC-1:0] vc_ok_o
);

  for (genvar o = 0; o < vc_router_pkg::NUM_PORTS; o++) begin : gen_out
    for (genvar v = 0; v < vc_router_pkg::NUM_VC; v++) begin : gen_vc
      logic                             take;
      logic                             give;
      logic [vc_router_pkg::CRED_W-1:0] cred_q;
      logic                             lock_q;
      logic [vc_router_pkg::PORT_W-1:0] owner_q;

      // a win spends a credit, a downstream pulse returns one
      assign take = win_i[o] && (win_flit_i[o].head.vc_id == vc_router_pkg::VC_ID_W'(v));
      assign give = credit_v_i[o] && (credit_id_i[o] == vc_router_pkg::VC_ID_W'(v));

      always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
          cred_q  <= vc_router_pkg::CRED_W'(vc_router_pkg::VC_DEPTH);
          lock_q  <= 1'b0;
          owner_q <= '0;
        end else begin
          cred_q <= cred_q - vc_router_pkg::CRED_W'(take) + vc_router_pkg::CRED_W'(give);
          // held from head to last flit
          if (take && win_flit_i[o].head.is_last) begin
            lock_q <= 1'b0;
          end else if (take && win_flit_i[o].head.is_head) begin
            lock_q  <= 1'b1;
            owner_q <= win_in_i[o];
          end
        end
      end

      // credit needed always, and a locked VC only serves its owner
      for (genvar i = 0; i < vc_router_pkg::NUM_PORTS; i++) begin : gen_in
        assign vc_ok_o[i][o][v] = (cred_q != '0) &&
                                  (!lock_q || (owner_q == vc_router_pkg::PORT_W'(i)));
      end

      // downstream never returns more credits than its buffer holds
      assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cred_q <= vc_router_pkg::CRED_W'(vc_router_pkg::VC_DEPTH));
    end
  end

endmodule

/* rtl/vc_switch_traversal.sv */
// switch-traversal register of one output, rewrites the look-ahead of head flits for the next hop
module vc_switch_traversal (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // own coordinate as {x, y}
  input  logic [2*vc_router_pkg::COORD_W-1:0]  xy_id_i,
  input  logic                                 win_i,
  input  vc_router_pkg::flit_u                 flit_i,
  output logic                                 data_v_o,
  output vc_router_pkg::flit_u                 data_o
);

  logic [vc_router_pkg::COORD_W-1:0] my_x;
  logic [vc_router_pkg::COORD_W-1:0] my_y;
  logic [vc_router_pkg::COORD_W-1:0] nb_x;
  logic [vc_router_pkg::COORD_W-1:0] nb_y;
  logic [vc_router_pkg::PORT_W-1:0]  next_dir;
  vc_router_pkg::flit_u              flit_rw;

  assign my_x = xy_id_i[2*vc_router_pkg::COORD_W-1:vc_router_pkg::COORD_W];
  assign my_y = xy_id_i[vc_router_pkg::COORD_W-1:0];

  // ====================
  // look-ahead route
  // ====================

  // current look-ahead names this output, so it also names the neighbour
  always_comb begin
    nb_x = my_x;
    nb_y = my_y;
    case (flit_i.head.la_dir)
      vc_router_pkg::DIR_E: nb_x = my_x + 1'b1;
      vc_router_pkg::DIR_W: nb_x = my_x - 1'b1;
      vc_router_pkg::DIR_N: nb_y = my_y + 1'b1;
      vc_router_pkg::DIR_S: nb_y = my_y - 1'b1;
      default: ;
    endcase
    // XY at the neighbour: x first, then y, then eject
    if (flit_i.head.la_dir == vc_router_pkg::DIR_L) begin
      next_dir = vc_router_pkg::DIR_L;
    end else if (flit_i.head.dst_x > nb_x) begin
      next_dir = vc_router_pkg::DIR_E;
    end else if (flit_i.head.dst_x < nb_x) begin
      next_dir = vc_router_pkg::DIR_W;
    end else if (flit_i.head.dst_y > nb_y) begin
      next_dir = vc_router_pkg::DIR_N;
    end else if (flit_i.head.dst_y < nb_y) begin
      next_dir = vc_router_pkg::DIR_S;
    end else begin
      next_dir = vc_router_pkg::DIR_L;
    end
    // bodies pass untouched
    flit_rw = flit_i;
    if (flit_i.head.is_head) begin
      flit_rw.head.la_dir = next_dir;
    end
  end

  // ====================
  // st register
  // ====================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_v_o <= 1'b0;
    end else begin
      data_v_o <= win_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (win_i) begin
      data_o <= flit_rw;
    end
  end

endmodule

/* rtl/vc_router.sv */
// top of the five-port mesh VC router: input FIFOs, two-stage switch allocation, credits, ST
module vc_router (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  // own coordinate as {x, y}
  input  logic [2*vc_router_pkg::COORD_W-1:0]                          xy_id_i,
  // flits in, credits back upstream
  input  logic [vc_router_pkg::NUM_PORTS-1:0]                          data_v_i,
  input  vc_router_pkg::flit_u [vc_router_pkg::NUM_PORTS-1:0]          data_i,
  output logic [vc_router_pkg::NUM_PORTS-1:0]                          credit_v_o,
  output logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::VC_ID_W-1:0] credit_id_o,
  // flits out, credits from downstream
  output logic [vc_router_pkg::NUM_PORTS-1:0]                          data_v_o,
  output vc_router_pkg::flit_u [vc_router_pkg::NUM_PORTS-1:0]          data_o,
  input  logic [vc_router_pkg::NUM_PORTS-1:0]                          credit_v_i,
  input  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::VC_ID_W-1:0] credit_id_i
);

  // requests [in][out] and the transpose [out][in]
  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::NUM_PORTS-1:0] req;
  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::NUM_PORTS-1:0] req_t;
  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::VC_ID_W-1:0]   req_vc;
  vc_router_pkg::flit_u [vc_router_pkg::NUM_PORTS-1:0]               req_flit;
  // grants [out][in] and the transpose [in][out]
  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::NUM_PORTS-1:0] grant;
  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::NUM_PORTS-1:0] grant_t;
  logic [vc_router_pkg::NUM_PORTS-1:0]                               win;
  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::PORT_W-1:0]    win_in;
  vc_router_pkg::flit_u [vc_router_pkg::NUM_PORTS-1:0]               win_flit;
  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::NUM_PORTS-1:0]
        [vc_router_pkg::NUM_VC-1:0]                                  vc_ok;

  // ====================
  // per port blocks
  // ====================

  for (genvar p = 0; p < vc_router_pkg::NUM_PORTS; p++) begin : gen_port
    vc_head_if u_hd ();

    vc_input_port u_input_port (
      .clk_i,
      .rst_n_i,
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p]),
      .hd          (u_hd.queue)
    );

    // granted by at most one output
    vc_sa_local u_sa_local (
      .clk_i,
      .rst_n_i,
      .hd         (u_hd.arb),
      .vc_ok_i    (vc_ok[p]),
      .grant_i    (|grant_t[p]),
      .req_o      (req[p]),
      .req_vc_o   (req_vc[p]),
      .req_flit_o (req_flit[p])
    );

    vc_sa_global u_sa_global (
      .clk_i,
      .rst_n_i,
      .req_i    (req_t[p]),
      .grant_o  (grant[p]),
      .win_o    (win[p]),
      .win_in_o (win_in[p])
    );

    vc_switch_traversal u_switch_traversal (
      .clk_i,
      .rst_n_i,
      .xy_id_i,
      .win_i    (win[p]),
      .flit_i   (win_flit[p]),
      .data_v_o (data_v_o[p]),
      .data_o   (data_o[p])
    );

    // no U-turns, a port never feeds its own output
    for (genvar q = 0; q < vc_router_pkg::NUM_PORTS; q++) begin : gen_xpose
      assign req_t[p][q]   = (p == q) ? 1'b0 : req[q][p];
      assign grant_t[p][q] = grant[q][p];
    end
  end

  // ====================
  // crossbar and VC map
  // ====================

  // static VC map, the output VC is the VC the local stage picked
  always_comb begin
    for (int o = 0; o < vc_router_pkg::NUM_PORTS; o++) begin
      win_flit[o]              = req_flit[win_in[o]];
      win_flit[o].head.vc_id   = req_vc[win_in[o]];
    end
  end

  vc_output_credits u_output_credits (
    .clk_i,
    .rst_n_i,
    .credit_v_i,
    .credit_id_i,
    .win_i      (win),
    .win_in_i   (win_in),
    .win_flit_i (win_flit),
    .vc_ok_o    (vc_ok)
  );

endmodule

/* test/tb_vc_router.sv */
// testbench of the VC router that injects packets from the case file and checks routes and credits
module tb_vc_router;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CASES = 16;

  logic                                                                    clk;
  logic                                                                    rst_n;
  logic [2*vc_router_pkg::COORD_W-1:0]                                     xy_id;
  logic [vc_router_pkg::NUM_PORTS-1:0]                                     data_v_i;
  vc_router_pkg::flit_u [vc_router_pkg::NUM_PORTS-1:0]                     data_i;
  logic [vc_router_pkg::NUM_PORTS-1:0]                                     credit_v_o;
  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::VC_ID_W-1:0]         credit_id_o;
  logic [vc_router_pkg::NUM_PORTS-1:0]                                     data_v_o;
  vc_router_pkg::flit_u [vc_router_pkg::NUM_PORTS-1:0]                     data_o;
  logic [vc_router_pkg::NUM_PORTS-1:0]                                     credit_v_i;
  logic [vc_router_pkg::NUM_PORTS-1:0][vc_router_pkg::VC_ID_W-1:0]         credit_id_i;

  // case words with the fields laid out as in the file
  logic [43:0] cases [MAX_CASES];
  int          num_cases;
  int          total_flits;
  int          limit;
  int          cycle;
  int          mismatch_errs;
  int          other_errs;
  int          done_cnt;
  logic        rst_q;
  logic [31:0] lfsr;

  // upstream side per input
  int port_q [vc_router_pkg::NUM_PORTS][$];
  int flit_k [vc_router_pkg::NUM_PORTS];
  int up_cred [vc_router_pkg::NUM_PORTS][vc_router_pkg::NUM_VC];
  int inj_cnt [vc_router_pkg::NUM_PORTS][vc_router_pkg::NUM_VC];
  int cred_cnt [vc_router_pkg::NUM_PORTS][vc_router_pkg::NUM_VC];
  int cred_total;

  // downstream side and scoreboard per output VC
  int ds_cred [vc_router_pkg::NUM_PORTS][vc_router_pkg::NUM_VC];
  int due_q [vc_router_pkg::NUM_PORTS][vc_router_pkg::NUM_VC][$];
  int cur [vc_router_pkg::NUM_PORTS][vc_router_pkg::NUM_VC];
  int pos [vc_router_pkg::NUM_PORTS][vc_router_pkg::NUM_VC];
  bit matched [MAX_CASES];

  vc_router u_vc_router (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .xy_id_i     (xy_id),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ====================
  // helpers
  // ====================

  // galois LFSR stepped once per bit taken
  function automatic logic [2:0] next_delay();
    logic [2:0] d;
    for (int b = 0; b < 3; b++) begin
      d[b] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return d;
  endfunction

  function automatic int src_port(int k);
    return int'(cases[k][43:40]);
  endfunction

  function automatic int pkt_vc(int k);
    return int'(cases[k][39:36]);
  endfunction

  function automatic int body_len(int k);
    return int'(cases[k][27:24]);
  endfunction

  // flit n of case k where 0 is the head
  function automatic vc_router_pkg::flit_u build_flit(int k, int n);
    vc_router_pkg::flit_u f;
    f = '0;
    f.head.vc_id = cases[k][36];
    if (n == 0) begin
      f.head.is_head = 1'b1;
      f.head.la_dir  = cases[k][6:4];
      f.head.dst_x   = cases[k][33:32];
      f.head.dst_y   = cases[k][29:28];
    end else begin
      f.body.is_last = (n == body_len(k));
      f.body.payload = cases[k][23:8] + 16'(n);
    end
    return f;
  endfunction

  // ====================
  // clocked models
  // ====================

  always @(posedge clk) begin
    int k;
    int v;
    bit sent;
    vc_router_pkg::flit_u f;
    cycle = cycle + 1;
    // outputs quiet from the first reset edge through the first cycle after reset
    if (cycle > 1 && (!rst_n || !rst_q)) begin
      assert ((data_v_o == '0) && (credit_v_o == '0)) else begin
        other_errs++;
        $display("t=%0t output valid or credit pulse seen around reset", $time);
      end
    end
    rst_q <= rst_n;
    if (rst_n) begin
      // credits back from the router
      for (int p = 0; p < vc_router_pkg::NUM_PORTS; p++) begin
        if (credit_v_o[p]) begin
          v = int'(credit_id_o[p]);
          cred_cnt[p][v]++;
          cred_total++;
          up_cred[p][v]++;
          assert (up_cred[p][v] <= vc_router_pkg::VC_DEPTH) else begin
            other_errs++;
            $display("t=%0t input %0d vc %0d got more credits than its depth", $time, p, v);
          end
        end
      end
      // scoreboard and downstream buffer
      for (int o = 0; o < vc_router_pkg::NUM_PORTS; o++) begin
        if (data_v_o[o]) begin
          f = data_o[o];
          v = int'(f.head.vc_id);
          assert (ds_cred[o][v] > 0) else begin
            other_errs++;
            $display("t=%0t flit on output %0d vc %0d without downstream credit", $time, o, v);
          end
          ds_cred[o][v]--;
          due_q[o][v].push_back(cycle + int'(next_delay()));
          if (f.head.is_head) begin
            assert (cur[o][v] < 0) else begin
              other_errs++;
              $display("t=%0t packets interleaved on output %0d vc %0d", $time, o, v);
            end
            k = -1;
            for (int c = 0; c < num_cases; c++) begin
              if (k < 0 && !matched[c] && int'(cases[c][7:4]) == o && pkt_vc(c) == v &&
                  f.head.dst_x == cases[c][33:32] && f.head.dst_y == cases[c][29:28]) begin
                k = c;
              end
            end
            if (k < 0) begin
              other_errs++;
              $display("t=%0t head on output %0d vc %0d matches no packet", $time, o, v);
            end else begin
              matched[k] = 1'b1;
              cur[o][v] = k;
              pos[o][v] = 0;
              assert (f.head.la_dir == cases[k][2:0]) else begin
                mismatch_errs++;
                $display("Mismatch t=%0t data_o[%0d].la_dir exp=%0d got=%0d",
                         $time, o, cases[k][2:0], f.head.la_dir);
              end
            end
          end else if (cur[o][v] < 0) begin
            other_errs++;
            $display("t=%0t body flit on output %0d vc %0d without a head", $time, o, v);
          end else begin
            k = cur[o][v];
            pos[o][v]++;
            assert (f.body.payload == cases[k][23:8] + 16'(pos[o][v])) else begin
              mismatch_errs++;
              $display("Mismatch t=%0t data_o[%0d].payload exp=%h got=%h", $time, o,
                       cases[k][23:8] + 16'(pos[o][v]), f.body.payload);
            end
            assert (f.body.is_last == (pos[o][v] == body_len(k))) else begin
              mismatch_errs++;
              $display("Mismatch t=%0t data_o[%0d].is_last exp=%0d got=%0d", $time, o,
                       (pos[o][v] == body_len(k)), f.body.is_last);
            end
            if (f.body.is_last || pos[o][v] >= body_len(k)) begin
              cur[o][v] = -1;
              done_cnt++;
            end
          end
        end
        // at most one credit per output and cycle
        sent = 1'b0;
        credit_v_i[o] <= 1'b0;
        for (int c = 0; c < vc_router_pkg::NUM_VC; c++) begin
          if (!sent && due_q[o][c].size() > 0 && due_q[o][c][0] <= cycle) begin
            void'(due_q[o][c].pop_front());
            ds_cred[o][c]++;
            sent = 1'b1;
            credit_v_i[o]  <= 1'b1;
            credit_id_i[o] <= vc_router_pkg::VC_ID_W'(c);
          end
        end
      end
      // packets of one input are injected in file order
      for (int p = 0; p < vc_router_pkg::NUM_PORTS; p++) begin
        data_v_i[p] <= 1'b0;
        if (rst_q && port_q[p].size() > 0) begin
          k = port_q[p][0];
          v = pkt_vc(k);
          if (up_cred[p][v] > 0) begin
            data_v_i[p] <= 1'b1;
            data_i[p]   <= build_flit(k, flit_k[p]);
            up_cred[p][v]--;
            inj_cnt[p][v]++;
            flit_k[p]++;
            if (flit_k[p] > body_len(k)) begin
              flit_k[p] = 0;
              void'(port_q[p].pop_front());
            end
          end
        end
      end
    end
  end

  // ====================
  // main sequence
  // ====================

  initial begin
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    rst_n       = 1'b0;
    rst_q       = 1'b0;
    xy_id       = {2'd1, 2'd1};
    lfsr        = 32'h778745c3;
    cycle       = 0;
    mismatch_errs = 0;
    other_errs  = 0;
    done_cnt    = 0;
    cred_total  = 0;
    total_flits = 0;
    for (int p = 0; p < vc_router_pkg::NUM_PORTS; p++) begin
      flit_k[p] = 0;
      for (int v = 0; v < vc_router_pkg::NUM_VC; v++) begin
        up_cred[p][v]  = vc_router_pkg::VC_DEPTH;
        ds_cred[p][v]  = vc_router_pkg::VC_DEPTH;
        inj_cnt[p][v]  = 0;
        cred_cnt[p][v] = 0;
        cur[p][v]      = -1;
        pos[p][v]      = 0;
      end
    end
    // unused slots keep port F, which ends the list
    for (int i = 0; i < MAX_CASES; i++) begin
      cases[i]   = {4'hF, 40'(i)};
      matched[i] = 1'b0;
    end
    $readmemh("test/vc_router_cases.txt", cases);
    num_cases = 0;
    while (num_cases < MAX_CASES && cases[num_cases][43:40] != 4'hF) begin
      port_q[src_port(num_cases)].push_back(num_cases);
      total_flits += body_len(num_cases) + 1;
      num_cases++;
    end
    limit = 40 * total_flits + 200;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // progress is read between edges, where the models have settled
    while (!(done_cnt == num_cases && cred_total == total_flits) && cycle < limit) begin
      @(negedge clk);
    end
    if (!(done_cnt == num_cases && cred_total == total_flits)) begin
      other_errs++;
      $display("timeout after %0d cycles, %0d of %0d packets done", cycle, done_cnt, num_cases);
    end
    for (int p = 0; p < vc_router_pkg::NUM_PORTS; p++) begin
      for (int v = 0; v < vc_router_pkg::NUM_VC; v++) begin
        assert (cred_cnt[p][v] == inj_cnt[p][v]) else begin
          mismatch_errs++;
          $display("Mismatch t=%0t credit_v_o[%0d] vc %0d pulses exp=%0d got=%0d",
                   $time, p, v, inj_cnt[p][v], cred_cnt[p][v]);
        end
      end
    end
    $display("errors: mismatch=%0d other=%0d", mismatch_errs, other_errs);
    if (mismatch_errs + other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* test/vc_router_cases.txt */
// one case per line, 11 hex digits: in_port vc dst_x dst_y body_len payload_seed(4) exp_out exp_la
// ports N=0 E=1 S=2 W=3 L=4, router at (1,1), body k carries payload_seed + k
40313a10011
31222b20010
10031c30030
20132d40000
01103e50024
30111f60044
00302170011
20203280012
41002390032
111214a0004
010125b0034
401226c0004

/* files.f */
rtl/vc_router_pkg.sv
rtl/vc_head_if.sv
rtl/vc_input_port.sv
rtl/vc_sa_local.sv
rtl/vc_sa_global.sv
rtl/vc_output_credits.sv
rtl/vc_switch_traversal.sv
rtl/vc_router.sv
test/tb_vc_router.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run, pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_vc_router -o sim_tb &&
./obj_dir/sim_tb | grep -F ">>> PASS" ||
{ echo "simulation failed"; exit 1; }
